/* src/fm_pkg.sv */
`default_nettype none

package fm_pkg;

    localparam int NUM_OPS  = 4;  // operator slices in the ring
    localparam int PHASE_W  = 16; // phase accumulator
    localparam int FNUM_W   = 10;
    localparam int BLOCK_W  = 3;  // octave shift
    localparam int TL_W     = 4;  // attenuation shift
    localparam int WS_W     = 2;
    localparam int ENV_W    = 8;  // 255 is full level
    localparam int WAVE_W   = 12; // signed, +-2047 full scale
    localparam int SAMPLE_W = 16;
    localparam int GAIN_W   = 3;
    localparam int ADDR_W   = 8;

    // per-operator register offsets
    localparam logic [ADDR_W-1:0] REG_FREQ   = 8'h00;
    localparam logic [ADDR_W-1:0] REG_LEVEL  = 8'h04;
    localparam logic [ADDR_W-1:0] REG_ENV    = 8'h08;
    localparam logic [ADDR_W-1:0] REG_KEY    = 8'h0C;
    localparam logic [ADDR_W-1:0] OP_STRIDE  = 8'h10;
    localparam logic [ADDR_W-1:0] REG_MASTER = 8'h40; // master gain, last valid address

    typedef logic [PHASE_W-1:0] phase_t;
    typedef logic [FNUM_W-1:0]  fnum_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [TL_W-1:0]    tl_t;
    typedef logic [WS_W-1:0]    ws_t;
    typedef logic [ENV_W-1:0]   env_t;
    typedef logic [GAIN_W-1:0]  gain_t;

    typedef logic signed [WAVE_W-1:0]   wave_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef enum logic [1:0] {
        ENV_IDLE    = 2'd0, // silent, level 0
        ENV_ATTACK  = 2'd1, // ramping up by ar per tick
        ENV_HOLD    = 2'd2, // full level while key held
        ENV_RELEASE = 2'd3  // ramping down by rr per tick
    } env_state_t;

endpackage

`default_nettype wire

/* src/fm_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module fm_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fm_pkg::ADDR_W-1:0]  paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  fm_pkg::env_state_t         env_state [fm_pkg::NUM_OPS],
    output fm_pkg::fnum_t              fnum      [fm_pkg::NUM_OPS],
    output fm_pkg::block_t             block     [fm_pkg::NUM_OPS],
    output fm_pkg::tl_t                tl        [fm_pkg::NUM_OPS],
    output fm_pkg::ws_t                ws        [fm_pkg::NUM_OPS],
    output logic                       mod_en    [fm_pkg::NUM_OPS],
    output fm_pkg::env_t               ar        [fm_pkg::NUM_OPS],
    output fm_pkg::env_t               rr        [fm_pkg::NUM_OPS],
    output logic                       kon       [fm_pkg::NUM_OPS],
    output fm_pkg::gain_t              gain
);

    logic       addr_err;   // misaligned or past master
    logic       is_master;
    logic [1:0] op_idx;     // paddr[5:4]
    logic [3:0] reg_off;    // offset within operator block
    logic       wr_en;

    assign addr_err  = (paddr[1:0] != 2'b00) || (paddr > fm_pkg::REG_MASTER);
    assign is_master = (paddr == fm_pkg::REG_MASTER);
    assign op_idx    = paddr[5:4];
    assign reg_off   = paddr[3:0];
    assign wr_en     = psel && penable && pwrite && !addr_err; // commits at end of access

    assign pready  = 1'b1;                          // no wait states
    assign pslverr = psel && penable && addr_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fm_pkg::NUM_OPS; i++) begin
                fnum[i]   <= '0;
                block[i]  <= '0;
                tl[i]     <= '0;
                ws[i]     <= '0;
                mod_en[i] <= 1'b0;
                ar[i]     <= '0;
                rr[i]     <= '0;
                kon[i]    <= 1'b0;
            end
            gain <= '0;
        end else if (wr_en) begin
            if (is_master) begin
                gain <= pwdata[2:0];
            end else begin
                case (reg_off)
                    fm_pkg::REG_FREQ[3:0]: begin
                        fnum[op_idx]  <= pwdata[9:0];
                        block[op_idx] <= pwdata[12:10];
                    end
                    fm_pkg::REG_LEVEL[3:0]: begin
                        tl[op_idx]     <= pwdata[3:0];
                        ws[op_idx]     <= pwdata[5:4];
                        mod_en[op_idx] <= pwdata[6];
                    end
                    fm_pkg::REG_ENV[3:0]: begin
                        ar[op_idx] <= pwdata[7:0];
                        rr[op_idx] <= pwdata[15:8];
                    end
                    default: begin
                        kon[op_idx] <= pwdata[0]; // REG_KEY
                    end
                endcase
            end
        end
    end

    // readback mux, zero on bad address
    always_comb begin
        prdata = '0;
        if (!addr_err) begin
            if (is_master) begin
                prdata[2:0] = gain;
            end else begin
                case (reg_off)
                    fm_pkg::REG_FREQ[3:0]: begin
                        prdata[12:0] = {block[op_idx], fnum[op_idx]};
                    end
                    fm_pkg::REG_LEVEL[3:0]: begin
                        prdata[6:0] = {mod_en[op_idx], ws[op_idx], tl[op_idx]};
                    end
                    fm_pkg::REG_ENV[3:0]: begin
                        prdata[15:0] = {rr[op_idx], ar[op_idx]};
                    end
                    default: begin
                        prdata[2:0] = {env_state[op_idx], kon[op_idx]}; // live env state
                    end
                endcase
            end
        end
    end

    // access phase only while the slave is selected
    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    );

endmodule

`default_nettype wire

/* src/fm_operator.sv */
`timescale 1ns/1ns
`default_nettype none

module fm_operator (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_en,
    input  fm_pkg::fnum_t       fnum,
    input  fm_pkg::block_t      block,
    input  fm_pkg::tl_t         tl,
    input  fm_pkg::ws_t         ws,
    input  logic                mod_en,
    input  fm_pkg::env_t        ar,
    input  fm_pkg::env_t        rr,
    input  logic                kon,
    input  fm_pkg::wave_t       mod_in,  // previous slice in the ring
    output fm_pkg::wave_t       wave,
    output fm_pkg::env_state_t  env_state
);

    typedef logic [10:0] qtab_t [0:256]; // quarter wave incl. the peak

    // quarter sine, round(2047*sin), built at elaboration
    function automatic qtab_t build_qtab();
        qtab_t t;
        for (int i = 0; i <= 256; i++) begin
            t[i] = 11'($rtoi(2047.0 * $sin(6.283185307179586 * i / 1024.0) + 0.5));
        end
        return t;
    endfunction

    localparam qtab_t QTAB = build_qtab();

    fm_pkg::phase_t  phase_acc;
    fm_pkg::env_t    env_lvl;
    logic            kon_prev;      // kon sampled on last tick
    logic            kon_rise;
    logic            kon_fall;
    logic [8:0]      att_sum;       // level + ar, one carry bit
    fm_pkg::phase_t  phase_inc;
    fm_pkg::phase_t  eff_phase;
    logic [7:0]      q_idx;
    logic [10:0]     q_val;
    fm_pkg::wave_t   sine;
    fm_pkg::wave_t   raw_wave;
    logic signed [20:0] scaled;     // wave * env

    assign kon_rise  = kon && !kon_prev;
    assign kon_fall  = !kon && kon_prev;
    assign att_sum   = {1'b0, env_lvl} + {1'b0, ar};
    assign phase_inc = fm_pkg::phase_t'({6'b0, fnum} << block); // wraps mod 2^16

    // stage 1 - phase and envelope on the tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_acc <= '0;
            env_lvl   <= '0;
            kon_prev  <= 1'b0;
            env_state <= fm_pkg::ENV_IDLE;
        end else if (sample_en) begin
            phase_acc <= phase_acc + phase_inc;
            kon_prev  <= kon;
            if (kon_rise) begin
                env_state <= fm_pkg::ENV_ATTACK;   // retrigger from any state
            end else if (kon_fall) begin
                env_state <= fm_pkg::ENV_RELEASE;
            end else begin
                case (env_state)
                    fm_pkg::ENV_ATTACK: begin
                        if (att_sum >= 9'd255) begin
                            env_lvl   <= 8'd255;
                            env_state <= fm_pkg::ENV_HOLD;
                        end else begin
                            env_lvl <= att_sum[7:0];
                        end
                    end
                    fm_pkg::ENV_RELEASE: begin
                        if (env_lvl <= rr) begin
                            env_lvl   <= '0;       // floor at silence
                            env_state <= fm_pkg::ENV_IDLE;
                        end else begin
                            env_lvl <= env_lvl - rr;
                        end
                    end
                    default: begin
                        env_lvl <= env_lvl;        // idle / hold keep level
                    end
                endcase
            end
        end
    end

    // stage 2 - lookup and scaling
    assign eff_phase = mod_en ? phase_acc + fm_pkg::phase_t'({mod_in, 4'b0000}) : phase_acc;
    assign q_idx     = eff_phase[13:6];

    always_comb begin
        case (eff_phase[15:14])                     // quadrant
            2'd0:    q_val = QTAB[q_idx];
            2'd1:    q_val = QTAB[9'd256 - q_idx];  // mirrored
            2'd2:    q_val = QTAB[q_idx];
            default: q_val = QTAB[9'd256 - q_idx];
        endcase
        sine = eff_phase[15] ? -fm_pkg::wave_t'(q_val) : fm_pkg::wave_t'(q_val);
    end

    always_comb begin
        case (ws)
            2'd0:    raw_wave = sine;
            2'd1:    raw_wave = eff_phase[15] ? '0 : sine;        // half sine
            2'd2:    raw_wave = eff_phase[15] ? -12'sd2047 : 12'sd2047;
            default: raw_wave = $signed(eff_phase[15:4]);         // sawtooth
        endcase
    end

    assign scaled = raw_wave * $signed({1'b0, env_lvl});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wave <= '0;
        end else begin
            wave <= fm_pkg::wave_t'((scaled >>> 8) >>> tl);
        end
    end

    // attack never loses level, release never gains it
    a_env_attack_up: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sample_en && !kon_rise && !kon_fall && env_state == fm_pkg::ENV_ATTACK)
            |=> env_lvl >= $past(env_lvl)
    );
    a_env_release_down: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sample_en && !kon_rise && !kon_fall && env_state == fm_pkg::ENV_RELEASE)
            |=> env_lvl <= $past(env_lvl)
    );
    a_hold_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        env_state == fm_pkg::ENV_HOLD |-> env_lvl == 8'd255
    );

endmodule

`default_nettype wire

/* src/fm_mixer.sv */
`timescale 1ns/1ns
`default_nettype none

module fm_mixer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wave_valid,             // tick delayed by one
    input  fm_pkg::wave_t      waves [fm_pkg::NUM_OPS],
    input  fm_pkg::gain_t      gain,
    output fm_pkg::sample_t    sample,
    output logic               sample_valid
);

    localparam int ACC_W = fm_pkg::WAVE_W + 2 + 8; // room for 4 ops and shift by 7

    logic signed [ACC_W-1:0] acc;      // raw sum
    logic signed [ACC_W-1:0] shifted;  // after gain
    fm_pkg::sample_t         clamped;

    always_comb begin
        acc = '0;
        for (int i = 0; i < fm_pkg::NUM_OPS; i++) begin
            acc = acc + ACC_W'(waves[i]);  // sign extended
        end
        shifted = acc <<< gain;
        if (shifted > ACC_W'(32767)) begin
            clamped = 16'sh7FFF;
        end else if (shifted < -ACC_W'(32768)) begin
            clamped = -16'sh8000;
        end else begin
            clamped = fm_pkg::sample_t'(shifted);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= wave_valid;
            if (wave_valid) begin
                sample <= clamped; // held until next valid
            end
        end
    end

    // ticks are spaced, so the strobe is a lone pulse
    a_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid
    );

endmodule

`default_nettype wire

/* src/fm_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fm_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fm_pkg::ADDR_W-1:0]  paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       sample_en,
    output fm_pkg::sample_t            sample,
    output logic                       sample_valid
);

    fm_pkg::fnum_t       fnum      [fm_pkg::NUM_OPS];
    fm_pkg::block_t      block     [fm_pkg::NUM_OPS];
    fm_pkg::tl_t         tl        [fm_pkg::NUM_OPS];
    fm_pkg::ws_t         ws        [fm_pkg::NUM_OPS];
    logic                mod_en    [fm_pkg::NUM_OPS];
    fm_pkg::env_t        ar        [fm_pkg::NUM_OPS];
    fm_pkg::env_t        rr        [fm_pkg::NUM_OPS];
    logic                kon       [fm_pkg::NUM_OPS];
    fm_pkg::env_state_t  env_state [fm_pkg::NUM_OPS];
    fm_pkg::wave_t       waves     [fm_pkg::NUM_OPS];
    fm_pkg::gain_t       gain;
    logic                wave_valid; // operator outputs ready

    fm_regs u_regs (
        .clk, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .env_state, .fnum, .block, .tl, .ws, .mod_en, .ar, .rr, .kon,
        .gain
    );

    for (genvar i = 0; i < fm_pkg::NUM_OPS; i++) begin : g_op
        fm_operator u_op (
            .clk, .rst_n, .sample_en,
            .fnum      (fnum[i]),
            .block     (block[i]),
            .tl        (tl[i]),
            .ws        (ws[i]),
            .mod_en    (mod_en[i]),
            .ar        (ar[i]),
            .rr        (rr[i]),
            .kon       (kon[i]),
            .mod_in    (waves[(i + fm_pkg::NUM_OPS - 1) % fm_pkg::NUM_OPS]), // ring, op0 <- op3
            .wave      (waves[i]),
            .env_state (env_state[i])
        );
    end

    // one-cycle tick delay, matches operator output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wave_valid <= 1'b0;
        end else begin
            wave_valid <= sample_en;
        end
    end

    fm_mixer u_mixer (
        .clk, .rst_n,
        .wave_valid,
        .waves,
        .gain,
        .sample,
        .sample_valid
    );

endmodule

`default_nettype wire

/* verification/fm_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fm_tb;

    logic               clk;
    logic               rst_n;
    logic [7:0]         paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    logic               sample_en;
    fm_pkg::sample_t    sample;
    logic               sample_valid;

    // register mirror, one entry per operator
    int fnum_m [4];
    int blk_m  [4];
    int tl_m   [4];
    int ws_m   [4];
    int mod_m  [4];
    int ar_m   [4];
    int rr_m   [4];
    int kon_m  [4];
    int gain_m;
    // operator state as the rules evolve it
    int phase_m [4];
    int env_m   [4];
    int kprev_m [4];              // kon seen on the last tick
    fm_pkg::env_state_t st_m [4];

    int errors;
    logic [8*24-1:0] cur_name;

    fm_top dut (
        .clk, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .sample_en, .sample, .sample_valid
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    task automatic check(input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %0s expected %0d actual %0d", cur_name, exp, act);
            errors++;
        end
    endtask

    // setup then access, inputs change on falling edges only
    task automatic apb_xfer(input bit wr, input int addr, input int wdata,
                            output int rdata, output int err);
        int n;
        @(negedge clk);
        paddr   = addr[7:0];
        pwdata  = wdata;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < 8);
        if (!pready) begin
            $display("APB access to %h never completed in test %0s", addr[7:0], cur_name);
            errors++;
        end
        rdata   = prdata;     // still the access cycle response
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    function automatic void mirror_write(input int a, input int d);
        int i;
        i = (a >> 4) & 3;
        if (a[1:0] != 0 || a > 'h40) begin
            return;           // rejected with pslverr
        end
        if (a == 'h40) begin
            gain_m = d & 7;
        end else begin
            case (a & 'hF)
                'h0: begin
                    fnum_m[i] = d & 'h3FF;
                    blk_m[i]  = (d >> 10) & 7;
                end
                'h4: begin
                    tl_m[i]  = d & 'hF;
                    ws_m[i]  = (d >> 4) & 3;
                    mod_m[i] = (d >> 6) & 1;
                end
                'h8: begin
                    ar_m[i] = d & 'hFF;
                    rr_m[i] = (d >> 8) & 'hFF;
                end
                default: kon_m[i] = d & 1;
            endcase
        end
    endfunction

    function automatic int wave_of(input int i, input int mod_in);
        int  eff;
        int  raw;
        real s;
        eff = (phase_m[i] + (mod_m[i] ? mod_in * 16 : 0)) & 'hFFFF;
        s   = 2047.0 * $sin(6.283185307179586 * (eff >> 6) / 1024.0);
        raw = (s >= 0.0) ? $rtoi(s + 0.5) : -$rtoi(0.5 - s); // round half away
        case (ws_m[i])
            1: raw = eff[15] ? 0 : raw;                  // negative half muted
            2: raw = eff[15] ? -2047 : 2047;
            3: raw = ((eff >> 4) >= 2048) ? (eff >> 4) - 4096 : eff >> 4;
            default: ;
        endcase
        return ((raw * env_m[i]) >>> 8) >>> tl_m[i];
    endfunction

    function automatic int expect_sample();
        int w [4];
        int sum;
        w   = '{default: 0};
        sum = 0;
        for (int k = 1; k <= 4; k++) begin
            w[k % 4] = wave_of(k % 4, w[(k + 3) % 4]); // op0 last, it takes op3
            sum += w[k % 4];
        end
        sum = sum <<< gain_m;
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return sum;
    endfunction

    function automatic void advance();
        for (int i = 0; i < 4; i++) begin
            phase_m[i] = (phase_m[i] + (fnum_m[i] << blk_m[i])) & 'hFFFF;
            if (kon_m[i] && !kprev_m[i]) begin
                st_m[i] = fm_pkg::ENV_ATTACK;     // level untouched on this tick
            end else if (!kon_m[i] && kprev_m[i]) begin
                st_m[i] = fm_pkg::ENV_RELEASE;
            end else if (st_m[i] == fm_pkg::ENV_ATTACK) begin
                env_m[i] = (env_m[i] + ar_m[i] >= 255) ? 255 : env_m[i] + ar_m[i];
                if (env_m[i] == 255) begin
                    st_m[i] = fm_pkg::ENV_HOLD;
                end
            end else if (st_m[i] == fm_pkg::ENV_RELEASE) begin
                env_m[i] = (env_m[i] <= rr_m[i]) ? 0 : env_m[i] - rr_m[i];
                if (env_m[i] == 0) begin
                    st_m[i] = fm_pkg::ENV_IDLE;
                end
            end
            kprev_m[i] = kon_m[i];
        end
    endfunction

    // sample out reflects the state before this tick's update
    task automatic do_tick(input int expected, input bit explicit_val);
        int exp_v;
        int n;
        exp_v = explicit_val ? expected : expect_sample();
        repeat (1 + $urandom % 6) @(negedge clk); // 3..8 cycles after the last tick
        sample_en = 1'b1;
        @(negedge clk);
        sample_en = 1'b0;
        advance();
        n = 1;                                     // cycles since the tick
        while (!sample_valid && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!sample_valid) begin
            $display("no sample_valid within 10 cycles of a tick in test %0s", cur_name);
            errors++;
        end else begin
            check(2, n);                           // strobe lands two cycles after the tick
            check(exp_v, sample);
        end
    endtask

    initial begin
        logic [8*24-1:0]  cmd;
        logic [8*128-1:0] line;
        int fd, code, a, d, e, n, rd, er, test_err, tests, failed;
        void'($urandom(5595));
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        sample_en = 1'b0;
        errors = 0;
        tests = 0;
        failed = 0;
        test_err = 0;
        gain_m = 0;
        for (int i = 0; i < 4; i++) begin
            {fnum_m[i], blk_m[i], tl_m[i], ws_m[i], mod_m[i]} = '0;
            {ar_m[i], rr_m[i], kon_m[i], phase_m[i], env_m[i], kprev_m[i]} = '0;
            st_m[i] = fm_pkg::ENV_IDLE;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("verification/fm_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/fm_tests.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": code = $fgets(line, fd);    // rest of a comment line
                    "test": begin
                        code = $fscanf(fd, "%s", cur_name);
                        test_err = errors;
                    end
                    "w": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        apb_xfer(1'b1, a, d, rd, er);
                        mirror_write(a, d);
                    end
                    "wa": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        for (int i = 0; i < 4; i++) begin
                            apb_xfer(1'b1, i * 16 + a, d, rd, er);
                            mirror_write(i * 16 + a, d);
                        end
                    end
                    "r": begin
                        code = $fscanf(fd, "%h %h %d", a, d, e);
                        apb_xfer(1'b0, a, 0, rd, er);
                        check(d, rd);
                        check(e, er);
                    end
                    "tick": begin
                        code = $fscanf(fd, "%d", n);
                        repeat (n) do_tick(0, 1'b0);
                    end
                    "exp": begin
                        code = $fscanf(fd, "%d", e);
                        do_tick(e, 1'b1);
                    end
                    "end": begin
                        tests++;
                        failed += (errors != test_err);
                        $display("%0s: %0s", cur_name, (errors == test_err) ? "ok" : "mismatch");
                    end
                    default: begin
                        $display("unknown token %0s in the test file", cmd);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d failing, %0d check errors", tests, failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/fm_tests.txt */
# tokens: test NAME | w ADDR DATA | wa OFFSET DATA (ops 0..3) | r ADDR DATA PSLVERR
# tick N (model checked) | exp SAMPLE (decimal, one tick) | end; ADDR and DATA in hex
test mixer_sat w 40 3 wa 00 1a00 wa 04 20 wa 08 ffff wa 0c 1
    exp 0 exp 0 exp 32767 exp -32768 w 40 1 exp 16312 exp -16320 wa 0c 0 tick 2 end
# readback, key state bits, bad addresses
test reg_access w 10 1fff r 10 1fff 0 w 14 3f r 14 3f 0 w 18 abcd r 18 abcd 0
    w 40 5 r 40 5 0 r 44 0 1 w 42 7 r 42 0 1 r 40 5 0
    w 1c 1 tick 1 r 1c 3 0 w 1c 0 tick 1 r 1c 6 0 tick 1 r 1c 0 0 end
test square_env w 40 0 w 00 1100 w 04 20 w 08 ffff w 0c 1 tick 12
    w 04 23 tick 6 w 0c 0 tick 2 end
test attack_release w 20 0955 w 24 30 w 28 4020 w 2c 1 tick 10
    w 2c 0 tick 6 r 2c 0 0 end
test sine_table w 10 14c5 w 14 00 w 18 ffff w 1c 1 tick 12 w 14 10 tick 12
    w 1c 0 tick 2 end
test ring_mod w 30 0ea1 w 34 20 w 38 ffff w 3c 1 w 00 0c40 w 04 70 w 08 ffff w 0c 1
    tick 16 w 0c 0 w 3c 0 tick 2 end

/* src.f */
src/fm_pkg.sv
src/fm_regs.sv
src/fm_operator.sv
src/fm_mixer.sv
src/fm_top.sv
verification/fm_tb.sv

/* Bender.yml */
package:
  name: fm_tone

sources:
  - src/fm_pkg.sv
  - src/fm_regs.sv
  - src/fm_operator.sv
  - src/fm_mixer.sv
  - src/fm_top.sv
  - target: test
    files:
      - verification/fm_tb.sv
